// ==== filelist.f ====
+incdir+include
src/rx_pkg.sv
src/signal_parser.sv
src/byte_fifo.sv
src/fcs_checker.sv
src/rx_frame_top.sv
bench/rx_frame_asserts.sv
bench/rx_frame_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the receive back end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module rx_frame_tb -o rx_frame_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/rx_frame_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

// ==== bench/rx_frame_tb.sv ====
`timescale 1ns/1ps

module rx_frame_tb;

    import rx_pkg::*;

    logic        clock;
    logic        reset;
    logic        in_valid_i;
    byte_t       in_byte_i;
    logic        in_ready_o;
    logic        out_valid_o;
    byte_t       out_byte_o;
    logic        out_last_o;
    logic        out_ready_i;
    logic        hdr_done_o;
    logic        hdr_ok_o;
    hdr_status_e hdr_status_o;
    rate_t       rate_o;
    pkt_len_t    len_o;
    logic        fcs_done_o;
    logic        fcs_ok_o;

    integer      seed;

    // input stream, bit 8 marks the third SIGNAL byte
    logic [8:0]  in_q[$];
    // expected output, {last, byte}
    logic [8:0]  exp_out[$];
    hdr_status_e exp_st[$];
    rate_t       exp_rate[$];
    pkt_len_t    exp_len[$];
    int          exp_out_before[$];
    logic        exp_fcs[$];

    int   total_out;
    int   out_count;
    int   cycle;
    int   limit;
    int   low_run;
    int   stall_left;
    logic hdr_pipe;
    logic hdr_due;
    logic fcs_due;
    logic saw_stall;
    logic saw_overlap;
    logic run_ok;
    logic fail_shown;

    rx_frame_top rx_frame_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // reflected IEEE CRC-32, one byte
    function automatic crc32_t crc_update(input crc32_t crc, input byte_t data);
        crc32_t c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic stop_with_error(input string msg);
        fail_shown = 1'b1;
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string what);
        stop_with_error($sformatf("MISMATCH at time %0t: %s", $time, what));
    endtask

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_header(input hdr_status_e exp_status, input rate_t exp_r,
                                input pkt_len_t exp_l);
        if (hdr_status_o !== exp_status) begin
            report_mismatch($sformatf("hdr_status_o %s, expected %s",
                                      hdr_status_o.name(), exp_status.name()));
        end
        if (hdr_ok_o !== (exp_status == st_ok)) begin
            report_mismatch($sformatf("hdr_ok_o %b for status %s", hdr_ok_o, exp_status.name()));
        end
        if (rate_o !== exp_r) begin
            report_mismatch($sformatf("rate_o %h, expected %h", rate_o, exp_r));
        end
        if (len_o !== exp_l) begin
            report_mismatch($sformatf("len_o %0d, expected %0d", len_o, exp_l));
        end
    endtask

    task automatic check_byte(input byte_t exp_b, input logic exp_last);
        if (out_byte_o !== exp_b || out_last_o !== exp_last) begin
            report_mismatch($sformatf("output byte %h last %b, expected %h last %b",
                                      out_byte_o, out_last_o, exp_b, exp_last));
        end
    endtask

    task automatic check_fcs(input logic exp_ok);
        if (fcs_ok_o !== exp_ok) begin
            report_mismatch($sformatf("fcs_ok_o %b, expected %b", fcs_ok_o, exp_ok));
        end
    endtask

    ////////////////////////////////////////
    // packet model
    ////////////////////////////////////////

    // kind 0 good, 1..4 single header fault, 5 combined, 6 bad body, 7 bad FCS
    task automatic add_packet(input int kind);
        rate_t       rate;
        pkt_len_t    len;
        logic        rsvd;
        logic [5:0]  tail;
        logic        par_ok;
        hdr_status_e status;
        sig_word_t   word;
        crc32_t      crc;
        byte_t       body[$];
        int          pos;
        rate   = rate_t'(8 + rand_below(8));
        len    = pkt_len_t'(4 + rand_below(37));
        rsvd   = 1'b0;
        tail   = '0;
        par_ok = 1'b1;
        status = st_ok;
        case (kind)
            1: begin
                par_ok = 1'b0;
                status = st_parity_fail;
            end
            2: begin
                rsvd   = 1'b1;
                status = st_wrong_rsvd;
            end
            3: begin
                tail   = 6'(1 + rand_below(63));
                status = st_wrong_tail;
            end
            4: begin
                rate   = rate_t'(rand_below(8));
                status = st_unsupported_rate;
            end
            5: begin
                // several faults, the first in check order is reported
                tail = 6'(1 + rand_below(63));
                rate = rate_t'(rand_below(8));
                pos  = rand_below(3);
                if (pos == 0) begin
                    par_ok = 1'b0;
                    rsvd   = 1'b1;
                    status = st_parity_fail;
                end else if (pos == 1) begin
                    rsvd   = 1'b1;
                    status = st_wrong_rsvd;
                end else begin
                    status = st_wrong_tail;
                end
            end
            6: begin
                // need at least one payload byte to corrupt
                if (len == pkt_len_t'(4)) begin
                    len = pkt_len_t'(5);
                end
            end
            default: begin
            end
        endcase
        word     = {tail, 1'b0, len, rsvd, rate};
        // even parity over bits 17..0
        word[17] = (^word[16:0]) ^ ~par_ok;
        in_q.push_back({1'b0, word[7:0]});
        in_q.push_back({1'b0, word[15:8]});
        in_q.push_back({1'b1, word[23:16]});
        exp_st.push_back(status);
        exp_rate.push_back(rate);
        exp_len.push_back(len);
        exp_out_before.push_back(total_out);
        if (status == st_ok) begin
            crc = 32'hFFFF_FFFF;
            for (int i = 0; i < int'(len) - 4; i++) begin
                body.push_back(byte_t'(rand_below(256)));
                crc = crc_update(crc, body[i]);
            end
            crc = ~crc;
            // FCS goes out low byte first
            for (int i = 0; i < 4; i++) begin
                body.push_back(crc[8*i +: 8]);
            end
            if (kind == 6 || kind == 7) begin
                pos = (kind == 6) ? rand_below(int'(len) - 4) : int'(len) - 4 + rand_below(4);
                body[pos] = body[pos] ^ byte_t'(8'h01 << rand_below(8));
            end
            foreach (body[i]) begin
                in_q.push_back({1'b0, body[i]});
                exp_out.push_back({i == int'(len) - 1, body[i]});
            end
            exp_fcs.push_back(kind != 6 && kind != 7);
            total_out += int'(len);
        end
    endtask

    ////////////////////////////////////////
    // one clock cycle, called on the falling edge
    ////////////////////////////////////////

    task automatic run_cycle();
        // registered strobes from the last rising edge
        if (hdr_done_o !== hdr_due) begin
            report_mismatch($sformatf("hdr_done_o %b, expected %b", hdr_done_o, hdr_due));
        end
        if (hdr_due) begin
            if (out_count < exp_out_before[0]) begin
                saw_overlap = 1'b1;
            end
            check_header(exp_st[0], exp_rate[0], exp_len[0]);
            exp_st.delete(0);
            exp_rate.delete(0);
            exp_len.delete(0);
            exp_out_before.delete(0);
        end
        if (fcs_done_o !== fcs_due) begin
            report_mismatch($sformatf("fcs_done_o %b, expected %b", fcs_done_o, fcs_due));
        end
        if (fcs_due) begin
            check_fcs(exp_fcs[0]);
            exp_fcs.delete(0);
        end
        hdr_due  = hdr_pipe;
        hdr_pipe = 1'b0;
        fcs_due  = 1'b0;

        // input side, byte held until accepted
        if (in_q.size() > 0) begin
            in_valid_i = 1'b1;
            in_byte_i  = in_q[0][7:0];
        end else begin
            in_valid_i = 1'b0;
            in_byte_i  = '0;
        end
        // output side, random ready with long stalls now and then
        if (stall_left > 0) begin
            out_ready_i = 1'b0;
            stall_left--;
        end else if (rand_below(50) == 0) begin
            stall_left  = 20 + rand_below(40);
            out_ready_i = 1'b0;
        end else begin
            out_ready_i = (rand_below(4) != 0);
        end

        // in_ready_o only moves on the rising edge
        if (in_valid_i && in_ready_o) begin
            hdr_pipe = in_q[0][8];
            in_q.delete(0);
        end
        if (in_ready_o) begin
            low_run = 0;
        end else begin
            low_run++;
        end
        if (low_run >= 4) begin
            saw_stall = 1'b1;
        end

        if (out_valid_o) begin
            if (exp_out.size() == 0) begin
                stop_with_error("out_valid_o high with no byte left to expect");
            end else begin
                check_byte(exp_out[0][7:0], exp_out[0][8]);
                if (out_ready_i) begin
                    fcs_due = exp_out[0][8];
                    exp_out.delete(0);
                    out_count++;
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        seed        = 52;
        reset       = 1'b1;
        in_valid_i  = 1'b0;
        in_byte_i   = '0;
        out_ready_i = 1'b0;
        total_out   = 0;
        out_count   = 0;
        cycle       = 0;
        low_run     = 0;
        stall_left  = 0;
        hdr_pipe    = 1'b0;
        hdr_due     = 1'b0;
        fcs_due     = 1'b0;
        saw_stall   = 1'b0;
        saw_overlap = 1'b0;
        run_ok      = 1'b0;
        fail_shown  = 1'b0;

        for (int k = 0; k < 48; k++) begin
            add_packet((k % 4 == 0) ? (k / 4) % 8 : 0);
        end
        limit = 40 * in_q.size() + 2000;

        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        if (in_ready_o !== 1'b1 || hdr_done_o !== 1'b0 || out_valid_o !== 1'b0 ||
            fcs_done_o !== 1'b0) begin
            report_mismatch("outputs not at their reset values");
        end

        while (in_q.size() != 0 || exp_st.size() != 0 || exp_out.size() != 0 ||
               exp_fcs.size() != 0) begin
            run_cycle();
            @(negedge clock);
            cycle++;
            if (cycle > limit) begin
                stop_with_error($sformatf("timeout after %0d cycles, %0d output bytes missing",
                                          cycle, exp_out.size()));
            end
        end

        if (!saw_stall) begin
            stop_with_error("in_ready_o never stayed low during an output stall");
        end else if (!saw_overlap) begin
            stop_with_error("no header finished while an earlier body was still draining");
        end else begin
            run_ok = 1'b1;
            $display("TESTS PASSED");
            $finish;
        end
    end

    final begin
        if (!run_ok && !fail_shown) begin
            $display("TESTS FAILED");
        end
    end

endmodule

// ==== bench/rx_frame_asserts.sv ====
`timescale 1ns/1ps
`include "rx_macros.svh"

module rx_frame_asserts (
    input logic                                     clock,
    input logic                                     reset,
    input logic [$clog2(`RX_FIFO_DEPTH + 1)-1:0]    fill,
    input logic                                     spend,
    input rx_pkg::credit_t                          credits,
    input rx_pkg::parser_state_e                    state,
    input logic                                     in_ready
);

    import rx_pkg::*;

    ////////////////////////////////////////
    // FIFO side
    ////////////////////////////////////////

    a_fill_bound: assert property (@(posedge clock) disable iff (reset)
        fill <= `RX_FIFO_DEPTH)
        else $error("FIFO count above its depth");

    ////////////////////////////////////////
    // parser side, credit link
    ////////////////////////////////////////

    a_spend_credit: assert property (@(posedge clock) disable iff (reset)
        spend |-> credits != '0)
        else $error("byte pushed with zero credits");

    a_credit_bound: assert property (@(posedge clock) disable iff (reset)
        credits <= `RX_FIFO_DEPTH)
        else $error("credit count above FIFO depth");

    // no input while the header is evaluated
    a_ready_check: assert property (@(posedge clock) disable iff (reset)
        state == check_sig |-> !in_ready)
        else $error("in_ready_o high in check_sig");

endmodule

// unused side of each instance tied to a harmless value
bind signal_parser rx_frame_asserts parser_asserts_i (
    .clock    (clock),
    .reset    (reset),
    .fill     ('0),
    .spend    (1'b0),
    .credits  (credits),
    .state    (state),
    .in_ready (in_ready_o)
);

// free entries at the FIFO, every push must find one
bind byte_fifo rx_frame_asserts fifo_asserts_i (
    .clock    (clock),
    .reset    (reset),
    .fill     (count),
    .spend    (push_i),
    .credits  (rx_pkg::credit_t'(`RX_FIFO_DEPTH - count)),
    .state    (rx_pkg::collect_sig),
    .in_ready (1'b0)
);

// ==== src/rx_frame_top.sv ====
`timescale 1ns/1ps

module rx_frame_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid_i,
    input  rx_pkg::byte_t       in_byte_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    output rx_pkg::byte_t       out_byte_o,
    output logic                out_last_o,
    input  logic                out_ready_i,
    output logic                hdr_done_o,
    output logic                hdr_ok_o,
    output rx_pkg::hdr_status_e hdr_status_o,
    output rx_pkg::rate_t       rate_o,
    output rx_pkg::pkt_len_t    len_o,
    output logic                fcs_done_o,
    output logic                fcs_ok_o
);

    import rx_pkg::*;

    // parser to FIFO, credit link
    logic  push;
    byte_t push_byte;
    logic  push_last;
    logic  credit_return;

    // FIFO to checker
    logic  buf_valid;
    byte_t buf_byte;
    logic  buf_last;
    logic  pop;

    signal_parser signal_parser_i (
        .clock           (clock),
        .reset           (reset),
        .in_valid_i      (in_valid_i),
        .in_byte_i       (in_byte_i),
        .in_ready_o      (in_ready_o),
        .credit_return_i (credit_return),
        .push_o          (push),
        .push_byte_o     (push_byte),
        .push_last_o     (push_last),
        .hdr_done_o      (hdr_done_o),
        .hdr_ok_o        (hdr_ok_o),
        .hdr_status_o    (hdr_status_o),
        .rate_o          (rate_o),
        .len_o           (len_o)
    );

    byte_fifo byte_fifo_i (
        .clock           (clock),
        .reset           (reset),
        .push_i          (push),
        .push_byte_i     (push_byte),
        .push_last_i     (push_last),
        .pop_i           (pop),
        .credit_return_o (credit_return),
        .buf_valid_o     (buf_valid),
        .buf_byte_o      (buf_byte),
        .buf_last_o      (buf_last)
    );

    fcs_checker fcs_checker_i (
        .clock       (clock),
        .reset       (reset),
        .buf_valid_i (buf_valid),
        .buf_byte_i  (buf_byte),
        .buf_last_i  (buf_last),
        .pop_o       (pop),
        .out_ready_i (out_ready_i),
        .out_valid_o (out_valid_o),
        .out_byte_o  (out_byte_o),
        .out_last_o  (out_last_o),
        .fcs_done_o  (fcs_done_o),
        .fcs_ok_o    (fcs_ok_o)
    );

endmodule

// ==== src/fcs_checker.sv ====
`timescale 1ns/1ps
`include "rx_macros.svh"

module fcs_checker (
    input  logic          clock,
    input  logic          reset,
    input  logic          buf_valid_i,
    input  rx_pkg::byte_t buf_byte_i,
    input  logic          buf_last_i,
    output logic          pop_o,
    input  logic          out_ready_i,
    output logic          out_valid_o,
    output rx_pkg::byte_t out_byte_o,
    output logic          out_last_o,
    output logic          fcs_done_o,
    output logic          fcs_ok_o
);

    import rx_pkg::*;

    localparam crc32_t CRC_INIT = 32'hFFFF_FFFF;

    crc32_t crc_q;
    crc32_t crc_next;
    byte_t  byte_rev;
    logic   xfer;

    // one byte through the LFSR, bit 7 of data first
    function automatic crc32_t crc_fold(input crc32_t crc_in, input byte_t data);
        crc32_t c;
        logic   fb;
        c = crc_in;
        for (int i = 7; i >= 0; i--) begin
            fb = c[31] ^ data[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ `RX_CRC32_POLY;
            end
        end
        return c;
    endfunction

    ////////////////////////////////////////
    // output stream
    ////////////////////////////////////////

    // head stays put until popped, so the byte is stable under stall
    assign out_valid_o = buf_valid_i;
    assign out_byte_o  = buf_byte_i;
    assign out_last_o  = buf_last_i;

    assign xfer  = buf_valid_i & out_ready_i;
    assign pop_o = xfer;

    ////////////////////////////////////////
    // FCS
    ////////////////////////////////////////

    // bytes go in LSB first
    assign byte_rev = {<<{buf_byte_i}};
    assign crc_next = crc_fold(crc_q, byte_rev);

    always_ff @(posedge clock) begin
        if (reset) begin
            crc_q      <= CRC_INIT;
            fcs_done_o <= 1'b0;
            fcs_ok_o   <= 1'b0;
        end else begin
            fcs_done_o <= 1'b0;
            fcs_ok_o   <= 1'b0;
            if (xfer) begin
                if (buf_last_i) begin
                    // FCS bytes already folded in, expect the residue
                    fcs_done_o <= 1'b1;
                    fcs_ok_o   <= (crc_next == `RX_FCS_RESIDUE);
                    crc_q      <= CRC_INIT;
                end else begin
                    crc_q <= crc_next;
                end
            end
        end
    end

endmodule

// ==== src/byte_fifo.sv ====
`timescale 1ns/1ps
`include "rx_macros.svh"

module byte_fifo (
    input  logic          clock,
    input  logic          reset,
    input  logic          push_i,
    input  rx_pkg::byte_t push_byte_i,
    input  logic          push_last_i,
    input  logic          pop_i,
    output logic          credit_return_o,
    output logic          buf_valid_o,
    output rx_pkg::byte_t buf_byte_o,
    output logic          buf_last_o
);

    import rx_pkg::*;

    localparam int PTR_W = $clog2(`RX_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`RX_FIFO_DEPTH + 1);

    // entry is {last, byte}
    logic [8:0]       mem [`RX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // the sender holds credits, so no full check here
    assign do_pop = pop_i & buf_valid_o;

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            credit_return_o <= 1'b0;
        end else begin
            credit_return_o <= do_pop;
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push_i) begin
            mem[wr_ptr] <= {push_last_i, push_byte_i};
        end
    end

    // head of queue
    assign buf_valid_o = (count != '0);
    assign buf_byte_o  = mem[rd_ptr][7:0];
    assign buf_last_o  = mem[rd_ptr][8];

endmodule

// ==== src/signal_parser.sv ====
`timescale 1ns/1ps
`include "rx_macros.svh"

module signal_parser (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid_i,
    input  rx_pkg::byte_t       in_byte_i,
    output logic                in_ready_o,
    input  logic                credit_return_i,
    output logic                push_o,
    output rx_pkg::byte_t       push_byte_o,
    output logic                push_last_o,
    output logic                hdr_done_o,
    output logic                hdr_ok_o,
    output rx_pkg::hdr_status_e hdr_status_o,
    output rx_pkg::rate_t       rate_o,
    output rx_pkg::pkt_len_t    len_o
);

    import rx_pkg::*;

    localparam logic [1:0] SIG_LAST = 2'(`RX_SIGNAL_BYTES - 1);

    parser_state_e state;
    sig_word_t     sig_word;
    logic [1:0]    sig_cnt;
    credit_t       credits;
    pkt_len_t      remaining;
    logic          accept;
    logic          spend;

    // SIGNAL fields
    rate_t         sig_rate;
    logic          sig_rsvd;
    pkt_len_t      sig_len;
    logic          parity_err;
    logic [5:0]    sig_tail;
    hdr_status_e   check_status;

    assign sig_rate   = sig_word[3:0];
    assign sig_rsvd   = sig_word[4];
    assign sig_len    = sig_word[16:5];
    assign parity_err = ^sig_word[17:0];
    assign sig_tail   = sig_word[23:18];

    // first failing check wins
    always_comb begin
        if (parity_err) begin
            check_status = st_parity_fail;
        end else if (sig_rsvd) begin
            check_status = st_wrong_rsvd;
        end else if (|sig_tail) begin
            check_status = st_wrong_tail;
        end else if (!sig_rate[3]) begin
            check_status = st_unsupported_rate;
        end else begin
            check_status = st_ok;
        end
    end

    always_comb begin
        case (state)
            collect_sig:  in_ready_o = 1'b1;
            check_sig:    in_ready_o = 1'b0;
            forward_data: in_ready_o = (credits != '0);
            default:      in_ready_o = 1'b0;
        endcase
    end

    assign accept = in_valid_i & in_ready_o;
    assign spend  = accept && (state == forward_data);

    ////////////////////////////////////////
    // credit counter
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= credit_t'(`RX_FIFO_DEPTH);
        end else begin
            case ({spend, credit_return_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    ////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= collect_sig;
            sig_cnt      <= '0;
            remaining    <= '0;
            push_o       <= 1'b0;
            push_last_o  <= 1'b0;
            hdr_done_o   <= 1'b0;
            hdr_ok_o     <= 1'b0;
            hdr_status_o <= st_ok;
        end else begin
            // strobes default low
            hdr_done_o  <= 1'b0;
            push_o      <= 1'b0;
            push_last_o <= 1'b0;
            case (state)
                collect_sig: begin
                    if (accept) begin
                        if (sig_cnt == SIG_LAST) begin
                            sig_cnt <= '0;
                            state   <= check_sig;
                        end else begin
                            sig_cnt <= sig_cnt + 1'b1;
                        end
                    end
                end
                check_sig: begin
                    hdr_done_o   <= 1'b1;
                    hdr_ok_o     <= (check_status == st_ok);
                    hdr_status_o <= check_status;
                    remaining    <= sig_len;
                    // empty body goes straight back
                    if (check_status == st_ok && sig_len != '0) begin
                        state <= forward_data;
                    end else begin
                        state <= collect_sig;
                    end
                end
                forward_data: begin
                    if (accept) begin
                        push_o    <= 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == pkt_len_t'(1)) begin
                            push_last_o <= 1'b1;
                            state       <= collect_sig;
                        end
                    end
                end
                default: begin
                    state <= collect_sig;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clock) begin
        if (accept && state == collect_sig) begin
            sig_word <= {in_byte_i, sig_word[23:8]};
        end
        if (accept) begin
            push_byte_o <= in_byte_i;
        end
        if (state == check_sig) begin
            rate_o <= sig_rate;
            len_o  <= sig_len;
        end
    end

endmodule

// ==== src/rx_pkg.sv ====
`include "rx_macros.svh"

package rx_pkg;

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    // one decoded byte
    typedef logic [7:0] byte_t;

    // SIGNAL field, first byte in the low bits
    typedef logic [23:0] sig_word_t;

    // legacy rate code
    typedef logic [3:0] rate_t;

    // legacy length, FCS included
    typedef logic [11:0] pkt_len_t;

    typedef logic [31:0] crc32_t;

    // parser side view of free FIFO entries
    typedef logic [`RX_CREDIT_W-1:0] credit_t;

    ////////////////////////////////////////
    // enums
    ////////////////////////////////////////

    // SIGNAL check result, listed in check priority
    typedef enum logic [2:0] {
        st_ok               = 3'd0,
        st_parity_fail      = 3'd1,
        st_wrong_rsvd       = 3'd2,
        st_wrong_tail       = 3'd3,
        st_unsupported_rate = 3'd4
    } hdr_status_e;

    typedef enum logic [1:0] {
        collect_sig  = 2'd0,
        check_sig    = 2'd1,
        forward_data = 2'd2
    } parser_state_e;

endpackage

// ==== include/rx_macros.svh ====
`ifndef RX_MACROS_SVH
`define RX_MACROS_SVH

////////////////////////////////////////
// buffer and credit link
////////////////////////////////////////

// entries in the byte FIFO, also the initial credit count
`define RX_FIFO_DEPTH 8

// wide enough to hold the full depth
`define RX_CREDIT_W 4

////////////////////////////////////////
// frame check sequence
////////////////////////////////////////

// CRC-32 generator, MSB-first form
`define RX_CRC32_POLY 32'h04C11DB7

// register value after a good frame plus its FCS
`define RX_FCS_RESIDUE 32'hC704DD7B

// legacy SIGNAL field length in bytes
`define RX_SIGNAL_BYTES 3

`endif
